//--- plat_top.f
+incdir+hdl
hdl/plat_cfg_pkg.sv
hdl/host_chan_pkg.sv
hdl/host_chan_if.sv
hdl/host_chan_mux.sv
hdl/host_chan_reg.sv
hdl/plat_top.sv
tests/plat_top_assertions.sv
tests/plat_top_tb.sv

//--- Makefile
# Verilator build and run for the platform host channel testbench

VERILATOR ?= verilator
TOP       ?= plat_top_tb
FLIST     ?= plat_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert -Wno-fatal

SRCS := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv) tests/plat_top_golden.txt
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/plat_top_golden.txt
// port op addr data afu_tag host_tag, all hex, one transaction per line
// op is 0 for a read and 1 for a write, host_tag is the port above the AFU tag
0 1 1000 a5a50000 01 01
1 0 2004 00000000 02 42
2 1 3008 12345678 03 83
3 0 400c 00000000 04 c4
0 0 1010 00000000 05 05
1 1 2014 cafef00d 06 46
2 0 3018 00000000 07 87
3 1 401c 0badcafe 08 c8
0 1 1020 11112222 09 09
1 0 2024 00000000 0a 4a
2 1 3028 33334444 0b 8b
3 0 402c 00000000 0c cc
0 0 1030 00000000 3f 3f
1 1 2034 55556666 20 60
2 0 3038 00000000 10 90
3 1 403c 77778888 2a ea

//--- tests/plat_top_tb.sv
`include "plat_params.svh"

module plat_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TX = 16;
    localparam int NP     = `PLAT_NUM_PORTS;
    localparam int STAGES = `PLAT_REG_STAGES;

    logic                             pClk;
    logic                             arst_n;
    logic [NP-1:0]                    afu_req_valid;
    logic [NP-1:0]                    afu_req_op;
    logic [NP-1:0][`PLAT_ADDR_W-1:0]  afu_req_addr;
    logic [NP-1:0][`PLAT_DATA_W-1:0]  afu_req_data;
    logic [NP-1:0][`PLAT_AFU_TAG_W-1:0] afu_req_tag;
    logic [NP-1:0]                    afu_credit;
    logic [NP-1:0]                    afu_rsp_valid;
    logic [NP-1:0][`PLAT_DATA_W-1:0]  afu_rsp_data;
    logic [NP-1:0][`PLAT_AFU_TAG_W-1:0] afu_rsp_tag;
    logic                             host_req_valid;
    logic                             host_req_op;
    logic [`PLAT_ADDR_W-1:0]          host_req_addr;
    logic [`PLAT_DATA_W-1:0]          host_req_data;
    logic [7:0]                       host_req_tag;
    logic                             host_credit;
    logic                             host_rsp_valid;
    logic [`PLAT_DATA_W-1:0]          host_rsp_data;
    logic [7:0]                       host_rsp_tag;

    // Golden lines are flat, six words per transaction
    logic [31:0] gold [NUM_TX*6];
    int          send_q [NP][$];
    int          pend_q [NP][$];
    int          afu_cred [NP];
    int          sent [NP];
    int          pulses [NP];
    // Expected responses, oldest first, at most one per cycle
    int          exp_due [$];
    int          exp_port [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_tag [$];
    int          phase;
    int          cyc;
    int          errors;
    int          test_err_start;
    int          tests_pass;
    int          tests_fail;
    int          host_reqs;
    int          granted;
    int          rr_next;
    bit          running;
    string       test_name;
    logic [31:0] lfsr;

    plat_top u_dut (.*);

    initial
    begin
        pClk = 1'b0;
        forever #2 pClk = ~pClk;
    end

    always @(posedge pClk)
        cyc++;

    // Ends a run that stops making progress
    initial
    begin
        #(NUM_TX * 40 * 4);
        $display("Timeout: the transactions did not complete in %0d cycles", NUM_TX * 40);
        $display("SIMULATION FAILED");
        $finish;
    end

    // One bit per step of a Galois LFSR
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    task automatic report_value(string field, logic [31:0] exp, logic [31:0] act);
        $display("FAIL %s %s expected %h actual %h", test_name, field, exp, act);
        errors++;
    endtask

    task automatic report_text(string msg);
        $display("ERROR in %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        if (errors == test_err_start)
        begin
            $display("PASS %s", test_name);
            tests_pass++;
        end
        else
        begin
            $display("FAIL %s with %0d errors", test_name, errors - test_err_start);
            tests_fail++;
        end
    endtask

    task automatic pop_expected();
        void'(exp_due.pop_front());
        void'(exp_port.pop_front());
        void'(exp_data.pop_front());
        void'(exp_tag.pop_front());
    endtask

    // A response must land on its own port exactly when it is due
    task automatic check_responses();
        for (int p = 0; p < NP; p++)
        begin
            if (afu_rsp_valid[p])
            begin
                if (exp_due.size() == 0 || exp_due[0] != cyc || exp_port[0] != p)
                    report_text($sformatf("unexpected response on port %0d", p));
                else
                begin
                    if (afu_rsp_data[p] !== exp_data[0])
                        report_value("rsp_data", exp_data[0], afu_rsp_data[p]);
                    if (afu_rsp_tag[p] !== exp_tag[0][5:0])
                        report_value("rsp_tag", exp_tag[0], 32'(afu_rsp_tag[p]));
                    pop_expected();
                end
            end
        end
        if (exp_due.size() > 0 && exp_due[0] <= cyc)
        begin
            report_text($sformatf("response for port %0d never arrived", exp_port[0]));
            pop_expected();
        end
    endtask

    // Each credit pulse returns one credit and must match a sent request
    task automatic check_credits();
        for (int p = 0; p < NP; p++)
        begin
            if (afu_credit[p])
            begin
                pulses[p]++;
                afu_cred[p]++;
                if (pulses[p] > sent[p])
                    report_text($sformatf("credit pulse on port %0d with no request", p));
            end
        end
    endtask

    // Host model checks each request and answers reads at once
    task automatic check_host_req();
        int p;
        int i;
        host_rsp_valid = 1'b0;
        if (host_req_valid)
        begin
            host_reqs++;
            if (host_reqs > granted)
                report_text("host request sent without a host credit");
            p = int'(host_req_tag[7:6]);
            if (phase == 1)
            begin
                if (p != rr_next)
                    report_value("grant_port", rr_next, p);
                rr_next = (rr_next + 1) % NP;
            end
            if (pend_q[p].size() == 0)
                report_text($sformatf("host request from port %0d with none pending", p));
            else
            begin
                i = pend_q[p].pop_front();
                if (host_req_op !== gold[i*6+1][0])
                    report_value("req_op", gold[i*6+1], 32'(host_req_op));
                if (host_req_addr !== gold[i*6+2][15:0])
                    report_value("req_addr", gold[i*6+2], 32'(host_req_addr));
                if (host_req_data !== gold[i*6+3])
                    report_value("req_data", gold[i*6+3], host_req_data);
                if (host_req_tag !== gold[i*6+5][7:0])
                    report_value("req_tag", gold[i*6+5], 32'(host_req_tag));
                if (!gold[i*6+1][0])
                begin
                    host_rsp_valid = 1'b1;
                    host_rsp_data = ~{16'h0, gold[i*6+2][15:0]};
                    host_rsp_tag = gold[i*6+5][7:0];
                    exp_due.push_back(cyc + 1 + STAGES);
                    exp_port.push_back(p);
                    exp_data.push_back(host_rsp_data);
                    exp_tag.push_back(gold[i*6+4]);
                end
            end
        end
    endtask

    // AFU model sends the next golden line of a port while it holds a credit
    task automatic drive_afu();
        int i;
        for (int p = 0; p < NP; p++)
        begin
            afu_req_valid[p] = 1'b0;
            if (send_q[p].size() > 0 && afu_cred[p] > 0)
            begin
                i = send_q[p].pop_front();
                afu_req_valid[p] = 1'b1;
                afu_req_op[p] = gold[i*6+1][0];
                afu_req_addr[p] = gold[i*6+2][15:0];
                afu_req_data[p] = gold[i*6+3];
                afu_req_tag[p] = gold[i*6+4][5:0];
                afu_cred[p]--;
                sent[p]++;
                pend_q[p].push_back(i);
            end
        end
    endtask

    // Outputs are stable at the falling edge, inputs change there too
    always @(negedge pClk)
    begin
        if (running)
        begin
            if (phase == 0 && (host_req_valid || afu_credit != '0 || afu_rsp_valid != '0))
                report_text("output active before any host credit");
            check_responses();
            check_credits();
            check_host_req();
            drive_afu();
        end
    end

    initial
    begin
        int per_port [NP];
        arst_n = 1'b0;
        afu_req_valid = '0;
        afu_req_op = '0;
        afu_req_addr = '0;
        afu_req_data = '0;
        afu_req_tag = '0;
        host_credit = 1'b0;
        host_rsp_valid = 1'b0;
        host_rsp_data = '0;
        host_rsp_tag = '0;
        lfsr = 32'h5a47;
        $readmemh("tests/plat_top_golden.txt", gold);
        for (int p = 0; p < NP; p++)
        begin
            afu_cred[p] = `PLAT_MUX_FIFO_DEPTH;
            per_port[p] = 0;
        end
        for (int i = 0; i < NUM_TX; i++)
        begin
            send_q[gold[i*6]].push_back(i);
            per_port[gold[i*6]]++;
        end
        repeat (5) @(posedge pClk);
        @(negedge pClk);
        arst_n = 1'b1;
        @(negedge pClk);
        running = 1'b1;

        // All FIFOs fill while the host holds back its credits
        start_test("reset_idle");
        phase = 0;
        repeat (12) @(negedge pClk);
        end_test();

        // Single credits walk the arbiter through every port twice
        start_test("round_robin");
        phase = 1;
        repeat (2 * NP)
        begin
            @(negedge pClk);
            host_credit = 1'b1;
            granted++;
            @(negedge pClk);
            host_credit = 1'b0;
            while (host_reqs < granted)
                @(negedge pClk);
        end
        end_test();

        start_test("random_credit");
        phase = 2;
        while (granted < NUM_TX)
        begin
            @(negedge pClk);
            host_credit = lfsr_bit();
            if (host_credit)
                granted++;
        end
        @(negedge pClk);
        host_credit = 1'b0;
        while (host_reqs < NUM_TX || exp_due.size() > 0)
            @(negedge pClk);
        repeat (4) @(negedge pClk);
        for (int p = 0; p < NP; p++)
        begin
            if (send_q[p].size() != 0 || pend_q[p].size() != 0)
                report_text($sformatf("port %0d still has requests outstanding", p));
        end
        end_test();

        start_test("credit_count");
        for (int p = 0; p < NP; p++)
        begin
            if (pulses[p] != per_port[p])
                report_value($sformatf("pulses_port%0d", p), per_port[p], pulses[p]);
        end
        if (host_reqs != NUM_TX)
            report_value("host_reqs", NUM_TX, host_reqs);
        end_test();

        $display("Tests passed %0d failed %0d, errors %0d", tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tests/plat_top_assertions.sv
`include "plat_params.svh"

// Credit rules on both sides of the multiplexer
module plat_top_assertions
(
    input logic                         pClk,
    input logic                         arst_n,
    input logic [`PLAT_NUM_PORTS-1:0]   afu_req_valid,
    input logic [`PLAT_NUM_PORTS-1:0]   afu_credit,
    input logic                         host_credit,
    input logic                         grant_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // Credits spent by each AFU and not yet handed back
    logic [7:0] afu_held [`PLAT_NUM_PORTS];
    // Host credits received and not yet spent on a request
    logic [7:0] host_owed;

    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int p = 0; p < `PLAT_NUM_PORTS; p++)
                afu_held[p] <= '0;
            host_owed <= '0;
        end
        else
        begin
            for (int p = 0; p < `PLAT_NUM_PORTS; p++)
                afu_held[p] <= afu_held[p] + 8'(afu_req_valid[p]) - 8'(afu_credit[p]);
            host_owed <= host_owed + 8'(host_credit) - 8'(grant_valid);
        end
    end

    // A grant must be covered by a credit pulse from the host side
    grant_needs_credit: assert property (@(posedge pClk) disable iff (!arst_n)
        grant_valid |-> host_owed != 0)
        else $error("grant issued with no host credit");

    // An AFU request arrives only while its FIFO has room
    // A credit pulse in the same cycle has already freed one slot
    for (genvar p = 0; p < `PLAT_NUM_PORTS; p++)
    begin : g_port
        afu_in_credit: assert property (@(posedge pClk) disable iff (!arst_n)
            afu_req_valid[p] |->
                afu_held[p] - 8'(afu_credit[p]) < 8'(`PLAT_MUX_FIFO_DEPTH))
            else $error("AFU request on port %0d without a credit", p);
    end

endmodule

bind host_chan_mux plat_top_assertions u_assert
(
    .pClk(pClk),
    .arst_n(arst_n),
    .afu_req_valid(afu_req_valid),
    .afu_credit(afu_credit),
    .host_credit(to_fiu.credit),
    .grant_valid(grant_valid)
);

//--- hdl/plat_top.sv
`include "plat_params.svh"

// Platform host channel with four AFU ports on one host port
// The fields arrive as plain ports and are packed into the channel messages here
module plat_top
(
    input  logic                                         pClk,
    input  logic                                         arst_n,
    // AFU side, one entry per port
    input  logic [`PLAT_NUM_PORTS-1:0]                   afu_req_valid,
    input  logic [`PLAT_NUM_PORTS-1:0]                   afu_req_op,
    input  logic [`PLAT_NUM_PORTS-1:0][`PLAT_ADDR_W-1:0] afu_req_addr,
    input  logic [`PLAT_NUM_PORTS-1:0][`PLAT_DATA_W-1:0] afu_req_data,
    input  logic [`PLAT_NUM_PORTS-1:0][`PLAT_AFU_TAG_W-1:0] afu_req_tag,
    output logic [`PLAT_NUM_PORTS-1:0]                   afu_credit,
    output logic [`PLAT_NUM_PORTS-1:0]                   afu_rsp_valid,
    output logic [`PLAT_NUM_PORTS-1:0][`PLAT_DATA_W-1:0] afu_rsp_data,
    output logic [`PLAT_NUM_PORTS-1:0][`PLAT_AFU_TAG_W-1:0] afu_rsp_tag,
    // Host side, tags carry the port number in the upper bits
    output logic                                         host_req_valid,
    output logic                                         host_req_op,
    output logic [`PLAT_ADDR_W-1:0]                      host_req_addr,
    output logic [`PLAT_DATA_W-1:0]                      host_req_data,
    output logic [$bits(plat_cfg_pkg::host_tag_t)-1:0]   host_req_tag,
    input  logic                                         host_credit,
    input  logic                                         host_rsp_valid,
    input  logic [`PLAT_DATA_W-1:0]                      host_rsp_data,
    input  logic [$bits(plat_cfg_pkg::host_tag_t)-1:0]   host_rsp_tag
);

    host_chan_pkg::req_t   afu_req [`PLAT_NUM_PORTS];
    host_chan_pkg::rsp_t   afu_rsp [`PLAT_NUM_PORTS];
    host_chan_pkg::req_t   host_req;
    host_chan_pkg::rsp_t   host_rsp;

    host_chan_if mux_to_reg();

    // AFU tags enter with the port field cleared, the multiplexer fills it in
    for (genvar p = 0; p < `PLAT_NUM_PORTS; p++)
    begin : g_port
        assign afu_req[p].op          = host_chan_pkg::opcode_e'(afu_req_op[p]);
        assign afu_req[p].addr        = afu_req_addr[p];
        assign afu_req[p].data        = afu_req_data[p];
        assign afu_req[p].tag.port    = '0;
        assign afu_req[p].tag.afu_tag = afu_req_tag[p];
        assign afu_rsp_data[p]        = afu_rsp[p].data;
        assign afu_rsp_tag[p]         = afu_rsp[p].tag.afu_tag;
    end

    assign host_req_op   = host_req.op;
    assign host_req_addr = host_req.addr;
    assign host_req_data = host_req.data;
    assign host_req_tag  = host_req.tag;
    assign host_rsp.data = host_rsp_data;
    assign host_rsp.tag  = plat_cfg_pkg::host_tag_t'(host_rsp_tag);

    host_chan_mux u_mux
    (
        .pClk,
        .arst_n,
        .afu_req_valid,
        .afu_req,
        .afu_credit,
        .afu_rsp_valid,
        .afu_rsp,
        .to_fiu(mux_to_reg.to_afu)
    );

    host_chan_reg #(.N_REG_STAGES(`PLAT_REG_STAGES)) u_reg
    (
        .pClk,
        .arst_n,
        .to_afu(mux_to_reg.to_fiu),
        .to_fiu_req_valid(host_req_valid),
        .to_fiu_req(host_req),
        .to_fiu_credit(host_credit),
        .to_fiu_rsp_valid(host_rsp_valid),
        .to_fiu_rsp(host_rsp)
    );

endmodule

//--- hdl/host_chan_reg.sv
`include "plat_params.svh"

// Register stages on a host channel
// Requests travel toward the host, credits and responses back toward the AFU,
// and every path gets the same number of stages
module host_chan_reg
#(
    parameter int N_REG_STAGES = `PLAT_REG_STAGES
)
(
    input  logic                   pClk,
    input  logic                   arst_n,
    host_chan_if.to_fiu            to_afu,
    output logic                   to_fiu_req_valid,
    output host_chan_pkg::req_t    to_fiu_req,
    input  logic                   to_fiu_credit,
    input  logic                   to_fiu_rsp_valid,
    input  host_chan_pkg::rsp_t    to_fiu_rsp
);

    if (N_REG_STAGES == 0)
    begin : g_bypass
        assign to_fiu_req_valid = to_afu.req_valid;
        assign to_fiu_req       = to_afu.req;
        assign to_afu.credit    = to_fiu_credit;
        assign to_afu.rsp_valid = to_fiu_rsp_valid;
        assign to_afu.rsp       = to_fiu_rsp;
    end
    else
    begin : g_pipe
        logic [N_REG_STAGES-1:0]   req_valid_q;
        logic [N_REG_STAGES-1:0]   credit_q;
        logic [N_REG_STAGES-1:0]   rsp_valid_q;
        host_chan_pkg::req_t       req_q [N_REG_STAGES];
        host_chan_pkg::rsp_t       rsp_q [N_REG_STAGES];

        // Control bits, stage 0 takes the input and the rest shift along
        always_ff @(posedge pClk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                req_valid_q <= '0;
                credit_q    <= '0;
                rsp_valid_q <= '0;
            end
            else
            begin
                req_valid_q[0] <= to_afu.req_valid;
                credit_q[0]    <= to_fiu_credit;
                rsp_valid_q[0] <= to_fiu_rsp_valid;
                for (int s = 1; s < N_REG_STAGES; s++)
                begin
                    req_valid_q[s] <= req_valid_q[s-1];
                    credit_q[s]    <= credit_q[s-1];
                    rsp_valid_q[s] <= rsp_valid_q[s-1];
                end
            end
        end

        // Payloads follow their valid bits
        always_ff @(posedge pClk)
        begin
            req_q[0] <= to_afu.req;
            rsp_q[0] <= to_fiu_rsp;
            for (int s = 1; s < N_REG_STAGES; s++)
            begin
                req_q[s] <= req_q[s-1];
                rsp_q[s] <= rsp_q[s-1];
            end
        end

        assign to_fiu_req_valid = req_valid_q[N_REG_STAGES-1];
        assign to_fiu_req       = req_q[N_REG_STAGES-1];
        assign to_afu.credit    = credit_q[N_REG_STAGES-1];
        assign to_afu.rsp_valid = rsp_valid_q[N_REG_STAGES-1];
        assign to_afu.rsp       = rsp_q[N_REG_STAGES-1];
    end

endmodule

//--- hdl/host_chan_mux.sv
`include "plat_params.svh"

// Shares one host channel among the AFU ports
// Requests are queued per port, picked round robin while host credits are held
// and tagged with their source port so responses find their way back
module host_chan_mux
(
    input  logic                            pClk,
    input  logic                            arst_n,
    input  logic [`PLAT_NUM_PORTS-1:0]      afu_req_valid,
    input  host_chan_pkg::req_t             afu_req [`PLAT_NUM_PORTS],
    output logic [`PLAT_NUM_PORTS-1:0]      afu_credit,
    output logic [`PLAT_NUM_PORTS-1:0]      afu_rsp_valid,
    output host_chan_pkg::rsp_t             afu_rsp [`PLAT_NUM_PORTS],
    host_chan_if.to_afu                     to_fiu
);

    localparam int NUM_PORTS   = `PLAT_NUM_PORTS;
    localparam int DEPTH       = `PLAT_MUX_FIFO_DEPTH;
    localparam int PTR_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W       = $clog2(DEPTH + 1);
    localparam int HOST_CRED_W = 8;

    host_chan_pkg::req_t         fifo_head [NUM_PORTS];
    logic [NUM_PORTS-1:0]        fifo_empty;
    logic [NUM_PORTS-1:0]        fifo_pop;
    logic [HOST_CRED_W-1:0]      host_credits;
    plat_cfg_pkg::port_idx_t     rr_ptr;
    plat_cfg_pkg::port_idx_t     grant_port;
    plat_cfg_pkg::port_idx_t     cand_port;
    logic                        grant_valid;
    host_chan_pkg::rsp_t         rsp_q;

    // One FIFO per port
    // The AFU never sends without a credit, so a full FIFO is never written
    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_fifo
        host_chan_pkg::req_t   mem [DEPTH];
        logic [PTR_W-1:0]      wr_ptr;
        logic [PTR_W-1:0]      rd_ptr;
        logic [CNT_W-1:0]      count;

        always_ff @(posedge pClk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end
            else
            begin
                if (afu_req_valid[p])
                    wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                if (fifo_pop[p])
                    rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                count <= count + CNT_W'(afu_req_valid[p]) - CNT_W'(fifo_pop[p]);
            end
        end

        // Storage only, the pointers say what is valid
        always_ff @(posedge pClk)
        begin
            if (afu_req_valid[p])
                mem[wr_ptr] <= afu_req[p];
        end

        assign fifo_empty[p] = (count == '0);
        assign fifo_head[p]  = mem[rd_ptr];
        assign fifo_pop[p]   = grant_valid && (grant_port == plat_cfg_pkg::port_idx_t'(p));
    end

    // Round-robin pick, starting the search at rr_ptr
    // Nothing is granted while the host credit counter is empty
    always_comb
    begin
        grant_valid = 1'b0;
        grant_port  = rr_ptr;
        cand_port   = rr_ptr;
        if (host_credits != '0)
        begin
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                cand_port = plat_cfg_pkg::port_idx_t'((int'(rr_ptr) + i) % NUM_PORTS);
                if (!grant_valid && !fifo_empty[cand_port])
                begin
                    grant_valid = 1'b1;
                    grant_port  = cand_port;
                end
            end
        end
    end

    // The granted head goes out the same cycle with its tag widened
    always_comb
    begin
        to_fiu.req          = fifo_head[grant_port];
        to_fiu.req.tag.port = grant_port;
    end

    assign to_fiu.req_valid = grant_valid;

    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rr_ptr        <= '0;
            host_credits  <= '0;
            afu_credit    <= '0;
            afu_rsp_valid <= '0;
        end
        else
        begin
            // Next search starts just past the port that won
            if (grant_valid)
                rr_ptr <= (grant_port == plat_cfg_pkg::port_idx_t'(NUM_PORTS - 1)) ?
                          '0 : grant_port + 1'b1;
            host_credits <= host_credits + HOST_CRED_W'(to_fiu.credit)
                            - HOST_CRED_W'(grant_valid);
            // A forwarded request frees its FIFO slot, hand the credit back
            afu_credit <= fifo_pop;
            for (int p = 0; p < NUM_PORTS; p++)
                afu_rsp_valid[p] <= to_fiu.rsp_valid &&
                                    (to_fiu.rsp.tag.port == plat_cfg_pkg::port_idx_t'(p));
        end
    end

    // Response payload is shared by all ports, only the valid bits are routed
    always_ff @(posedge pClk)
    begin
        if (to_fiu.rsp_valid)
        begin
            rsp_q          <= to_fiu.rsp;
            rsp_q.tag.port <= '0;
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_rsp
        assign afu_rsp[p] = rsp_q;
    end

endmodule

//--- hdl/host_chan_if.sv
`include "plat_params.svh"

// One credit-controlled request/response channel
// The requester may only send while it holds a credit, each request costs one
// credit and every credit pulse from the receiver returns one
// There is no ready signal and responses are always accepted, so the
// outstanding credits bound everything in flight
interface host_chan_if;

    // Requester to receiver
    logic                  req_valid;
    host_chan_pkg::req_t   req;

    // Receiver to requester, credit is a single-cycle pulse
    logic                  credit;
    logic                  rsp_valid;
    host_chan_pkg::rsp_t   rsp;

    // Requester side of the channel
    modport to_afu
    (
        output req_valid, req,
        input  credit, rsp_valid, rsp
    );

    // Receiver side, facing the requester
    modport to_fiu
    (
        input  req_valid, req,
        output credit, rsp_valid, rsp
    );

endinterface

//--- hdl/host_chan_pkg.sv
`include "plat_params.svh"

package host_chan_pkg;

    // Request opcodes
    typedef enum logic [0:0] {
        OP_RD = 1'b0,
        OP_WR = 1'b1
    } opcode_e;

    // Request message
    // Data is ignored for reads
    typedef struct packed {
        opcode_e                   op;
        logic [`PLAT_ADDR_W-1:0]   addr;
        logic [`PLAT_DATA_W-1:0]   data;
        plat_cfg_pkg::host_tag_t   tag;
    } req_t;

    // Response message, routed back by the port field of its tag
    typedef struct packed {
        logic [`PLAT_DATA_W-1:0]   data;
        plat_cfg_pkg::host_tag_t   tag;
    } rsp_t;

endpackage

//--- hdl/plat_cfg_pkg.sv
`include "plat_params.svh"

package plat_cfg_pkg;

    // Index of one AFU port on the multiplexer
    typedef logic [$clog2(`PLAT_NUM_PORTS)-1:0] port_idx_t;

    // Tag as an AFU sees it
    typedef logic [`PLAT_AFU_TAG_W-1:0] afu_tag_t;

    // Host side tag with the source port in the upper bits
    // On the AFU side the port field is always zero
    typedef struct packed {
        port_idx_t port;
        afu_tag_t  afu_tag;
    } host_tag_t;

endpackage

//--- hdl/plat_params.svh
`ifndef PLAT_PARAMS_SVH
`define PLAT_PARAMS_SVH

// Number of AFU ports sharing the single host channel
`define PLAT_NUM_PORTS 4

// Host channel address and data widths
`define PLAT_ADDR_W 16
`define PLAT_DATA_W 32

// Tag width as seen by one AFU, before the port number is prepended
`define PLAT_AFU_TAG_W 6

// Per-port FIFO depth, which is also the credit count each AFU starts with
`define PLAT_MUX_FIFO_DEPTH 4

// Register stages between the multiplexer and the host
`define PLAT_REG_STAGES 1

`endif
